// ==== hdl/mem_arb_pkg.sv ====
/* Memory-sharing package
   Sizes, arbiter policy and matrix types, and the client access word */
package mem_arb_pkg;

  // ****************************************
  // Sizes
  // ****************************************
  localparam int NUM_CLIENTS = 4;
  localparam int ADDR_W      = 6;                    // 64 words
  localparam int DATA_W      = 16;
  localparam int CLIENT_W    = $clog2(NUM_CLIENTS);
  localparam int MEM_DEPTH   = 1 << ADDR_W;

  // ****************************************
  // Arbiter types
  // ****************************************
  typedef enum logic [1:0] {
    ARB_ROUND_ROBIN     = 2'd0,  // Highest drops to lowest
    ARB_DEC_ROUND_ROBIN = 2'd1,  // Lowest rises to highest
    ARB_LRU             = 2'd2,  // Winner drops to lowest
    ARB_MRU             = 2'd3   // Winner rises to highest
  } arb_policy_e;

  // Row r, column c set means client r beats client c
  typedef logic [NUM_CLIENTS-1:0][NUM_CLIENTS-1:0] prio_matrix_t;

  typedef struct packed {
    arb_policy_e  policy;
    logic         load;    // Overwrite matrix this cycle
    prio_matrix_t matrix;
  } arb_config_t;

  // Client 0 beats everyone, client 3 beats no one
  function automatic prio_matrix_t upper_triangle_ones();
    prio_matrix_t m;
    m = '0;
    for (int r = 0; r < NUM_CLIENTS; r++) begin
      for (int c = r + 1; c < NUM_CLIENTS; c++) begin
        m[r][c] = 1'b1;
      end
    end
    return m;
  endfunction

  localparam prio_matrix_t RESET_MATRIX = upper_triangle_ones();

  // ****************************************
  // Memory access
  // ****************************************
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;  // Ignored on reads
  } mem_access_t;

endpackage

// ==== hdl/matrix_arbiter.sv ====
/* Priority-matrix arbiter
   One-hot grant, four update policies and a full matrix load */
module matrix_arbiter (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  mem_arb_pkg::arb_config_t            i_cfg,
  input  logic [mem_arb_pkg::NUM_CLIENTS-1:0] i_request,
  output logic [mem_arb_pkg::NUM_CLIENTS-1:0] o_grant
);
  import mem_arb_pkg::*;

  prio_matrix_t prio_matrix;  // Full matrix, upper triangle from flops
  prio_matrix_t prio_next;

  // ****************************************
  // Matrix storage
  // ****************************************
  for (genvar r = 0; r < NUM_CLIENTS; r++) begin : g_row
    for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_col
      if (c > r) begin : g_upper
        logic beat_q;

        always_ff @(posedge i_clk or negedge i_rst_n) begin
          if (!i_rst_n) begin
            beat_q <= RESET_MATRIX[r][c];
          end else if (i_cfg.load) begin
            beat_q <= i_cfg.matrix[r][c];  // Load wins over policy update
          end else if (|i_request) begin
            beat_q <= prio_next[r][c];
          end
        end

        assign prio_matrix[r][c] = beat_q;
      end else if (c == r) begin : g_diag
        assign prio_matrix[r][c] = 1'b0;
      end else begin : g_lower
        assign prio_matrix[r][c] = ~prio_matrix[c][r];
      end
    end
  end

  // ****************************************
  // Grant
  // ****************************************
  // A requester wins when no other requester beats it
  always_comb begin : p_grant
    logic beaten;
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      beaten = 1'b0;
      for (int r = 0; r < NUM_CLIENTS; r++) begin
        if (r != c && i_request[r] && prio_matrix[r][c]) begin
          beaten = 1'b1;
        end
      end
      o_grant[c] = i_request[c] && !beaten;
    end
  end

  // ****************************************
  // Policy update
  // ****************************************
  function automatic prio_matrix_t next_matrix(
    arb_policy_e            policy,
    prio_matrix_t           cur,
    logic [NUM_CLIENTS-1:0] grant
  );
    logic [NUM_CLIENTS-1:0] target;  // Client that moves
    logic                   raise;   // Move to top, else to bottom
    prio_matrix_t           nxt;

    target = '0;
    raise  = 1'b0;
    case (policy)
      ARB_ROUND_ROBIN: begin
        for (int r = 0; r < NUM_CLIENTS; r++) begin
          // Beats everyone once its own diagonal bit is filled in
          target[r] = &(cur[r] | (NUM_CLIENTS'(1) << r));
        end
      end
      ARB_DEC_ROUND_ROBIN: begin
        for (int r = 0; r < NUM_CLIENTS; r++) begin
          target[r] = (cur[r] == '0);
        end
        raise = 1'b1;
      end
      ARB_LRU: begin
        target = grant;
      end
      ARB_MRU: begin
        target = grant;
        raise  = 1'b1;
      end
      default: begin
        target = '0;
      end
    endcase

    nxt = cur;
    for (int r = 0; r < NUM_CLIENTS; r++) begin
      for (int c = r + 1; c < NUM_CLIENTS; c++) begin
        if (target[c]) begin
          nxt[r][c] = !raise;
        end else if (target[r]) begin
          nxt[r][c] = raise;
        end
      end
    end
    return nxt;
  endfunction

  always_comb begin
    prio_next = next_matrix(i_cfg.policy, prio_matrix, o_grant);
  end

endmodule

// ==== hdl/client_port.sv ====
/* Client port
   Holds one pending access until granted, then passes the response back */
module client_port (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_acc_valid,
  input  mem_arb_pkg::mem_access_t       i_access,
  input  logic                           i_grant,
  input  logic                           i_rsp_valid,  // Response index matches this port
  input  logic [mem_arb_pkg::DATA_W-1:0] i_rsp_rdata,
  output logic                           o_request,
  output mem_arb_pkg::mem_access_t       o_access,
  output logic                           o_busy,
  output logic                           o_rsp_valid,
  output logic [mem_arb_pkg::DATA_W-1:0] o_rsp_rdata
);
  import mem_arb_pkg::*;

  logic        pending_q;  // Access waiting for grant
  logic        await_q;    // Granted, response due this cycle
  mem_access_t access_q;
  logic        accept;

  // Strobes while busy are dropped
  assign accept = i_acc_valid && !pending_q;

  // ****************************************
  // Control
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending_q <= 1'b0;
      await_q   <= 1'b0;
    end else begin
      if (accept) begin
        pending_q <= 1'b1;
      end else if (i_grant) begin
        pending_q <= 1'b0;
      end
      await_q <= pending_q && i_grant;  // Memory answers one cycle after grant
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (accept) begin
      access_q <= i_access;
    end
  end

  assign o_request = pending_q;
  assign o_access  = access_q;
  assign o_busy    = pending_q;  // Drops as the response pulse rises

  // ****************************************
  // Response
  // ****************************************
  assign o_rsp_valid = i_rsp_valid && await_q;
  assign o_rsp_rdata = o_rsp_valid ? i_rsp_rdata : '0;

endmodule

// ==== hdl/shared_ram.sv ====
/* Shared single-port RAM
   One access per cycle, registered response with client index and read data */
module shared_ram (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic                             i_valid,
  input  mem_arb_pkg::mem_access_t         i_access,
  input  logic [mem_arb_pkg::CLIENT_W-1:0] i_client,
  output logic                             o_rsp_valid,
  output logic [mem_arb_pkg::CLIENT_W-1:0] o_rsp_client,
  output logic [mem_arb_pkg::DATA_W-1:0]   o_rdata
);
  import mem_arb_pkg::*;

  logic [DATA_W-1:0]   mem [MEM_DEPTH];
  logic                rsp_valid_q;
  logic [CLIENT_W-1:0] rsp_client_q;
  logic [DATA_W-1:0]   rdata_q;

  // ****************************************
  // Storage
  // ****************************************
  always_ff @(posedge i_clk) begin
    if (i_valid && i_access.write) begin
      mem[i_access.addr] <= i_access.wdata;
    end
  end

  // ****************************************
  // Response
  // ****************************************
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= i_valid;  // Writes get a response too
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      rsp_client_q <= i_client;
      // Reads return the stored word, writes return zero
      rdata_q <= i_access.write ? '0 : mem[i_access.addr];
    end
  end

  assign o_rsp_valid  = rsp_valid_q;
  assign o_rsp_client = rsp_client_q;
  assign o_rdata      = rdata_q;

endmodule

// ==== hdl/mem_share_top.sv ====
/* Shared memory top
   Four client ports arbitrated by a priority matrix onto one RAM */
module mem_share_top (
  input  logic                                                         i_clk,
  input  logic                                                         i_rst_n,
  input  mem_arb_pkg::arb_config_t                                     i_cfg,
  input  logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          i_acc_valid,
  input  mem_arb_pkg::mem_access_t [mem_arb_pkg::NUM_CLIENTS-1:0]      i_access,
  output logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          o_busy,
  output logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          o_rsp_valid,
  output logic [mem_arb_pkg::NUM_CLIENTS-1:0][mem_arb_pkg::DATA_W-1:0] o_rsp_rdata
);
  import mem_arb_pkg::*;

  logic        [NUM_CLIENTS-1:0] request;
  logic        [NUM_CLIENTS-1:0] grant;
  mem_access_t [NUM_CLIENTS-1:0] port_access;
  logic        [NUM_CLIENTS-1:0] rsp_match;
  mem_access_t                   sel_access;
  logic        [CLIENT_W-1:0]    sel_client;
  logic                          ram_rsp_valid;
  logic        [CLIENT_W-1:0]    ram_rsp_client;
  logic        [DATA_W-1:0]      ram_rdata;

  // ****************************************
  // Client ports
  // ****************************************
  for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_port
    client_port u_port (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_acc_valid (i_acc_valid[i]),
      .i_access    (i_access[i]),
      .i_grant     (grant[i]),
      .i_rsp_valid (rsp_match[i]),
      .i_rsp_rdata (ram_rdata),
      .o_request   (request[i]),
      .o_access    (port_access[i]),
      .o_busy      (o_busy[i]),
      .o_rsp_valid (o_rsp_valid[i]),
      .o_rsp_rdata (o_rsp_rdata[i])
    );

    assign rsp_match[i] = ram_rsp_valid && (ram_rsp_client == CLIENT_W'(i));
  end

  matrix_arbiter u_arbiter (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cfg     (i_cfg),
    .i_request (request),
    .o_grant   (grant)
  );

  // ****************************************
  // Grant mux and index encode
  // ****************************************
  // Grant is one-hot, so OR-ing the masked inputs selects one
  always_comb begin
    sel_access = '0;
    sel_client = '0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      if (grant[i]) begin
        sel_access = sel_access | port_access[i];
        sel_client = sel_client | CLIENT_W'(i);
      end
    end
  end

  shared_ram u_ram (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (|grant),  // Any grant is an access
    .i_access     (sel_access),
    .i_client     (sel_client),
    .o_rsp_valid  (ram_rsp_valid),
    .o_rsp_client (ram_rsp_client),
    .o_rdata      (ram_rdata)
  );

endmodule

// ==== verification/arbiter_checker.sv ====
/* Arbiter checker
   Concurrent assertions on grant shape and matrix symmetry */
module arbiter_checker (
  input logic                                i_clk,
  input logic                                i_rst_n,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0] i_request,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0] i_grant,
  input mem_arb_pkg::prio_matrix_t           i_matrix
);
  import mem_arb_pkg::*;

  int fail_count = 0;  // Failed assertions so far

  // Lower triangle mirrors the upper one, diagonal stays clear
  function automatic bit triangle_ok(prio_matrix_t m);
    bit ok;
    ok = 1'b1;
    for (int r = 0; r < NUM_CLIENTS; r++) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (c < r && m[r][c] == m[c][r]) ok = 1'b0;
        if (c == r && m[r][c]) ok = 1'b0;
      end
    end
    return ok;
  endfunction

  a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(i_grant))
    else begin
      fail_count++;
      $error("Grant has more than one bit set");
    end

  a_grant_to_requester: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_grant & ~i_request) == '0)
    else begin
      fail_count++;
      $error("Grant given to a client with no request");
    end

  a_request_granted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    |i_request |-> |i_grant)
    else begin
      fail_count++;
      $error("Requests present but nothing granted");
    end

  a_matrix_triangle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    triangle_ok(i_matrix))
    else begin
      fail_count++;
      $error("Matrix lower triangle does not mirror upper");
    end

endmodule

bind matrix_arbiter arbiter_checker u_arbiter_checker (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .i_request (i_request),
  .i_grant   (o_grant),
  .i_matrix  (prio_matrix)
);

// ==== verification/mem_share_monitor.sv ====
/* Shared memory monitor
   Models memory, pending accesses and the priority matrix, checks every cycle */
module mem_share_monitor (
  input logic                                                         i_clk,
  input logic                                                         i_rst_n,
  input mem_arb_pkg::arb_config_t                                     i_cfg,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          i_acc_valid,
  input mem_arb_pkg::mem_access_t [mem_arb_pkg::NUM_CLIENTS-1:0]      i_access,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          i_busy,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0]                          i_rsp_valid,
  input logic [mem_arb_pkg::NUM_CLIENTS-1:0][mem_arb_pkg::DATA_W-1:0] i_rsp_rdata
);
  import mem_arb_pkg::*;

  logic [DATA_W-1:0]      model_mem [MEM_DEPTH];
  prio_matrix_t           model_matrix;
  logic [NUM_CLIENTS-1:0] model_pending;
  mem_access_t            model_access [NUM_CLIENTS];
  logic                   exp_valid;
  int                     exp_client;
  logic [DATA_W-1:0]      exp_data;
  string                  test_name = "reset";
  int                     error_count = 0;
  int                     test_errors = 0;

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  // ****************************************
  // Reference model
  // ****************************************
  // Winner is the requester that no other requester beats
  function automatic logic [NUM_CLIENTS-1:0] ref_grant(prio_matrix_t m,
                                                       logic [NUM_CLIENTS-1:0] req);
    logic [NUM_CLIENTS-1:0] g;
    g = req;
    for (int c = 0; c < NUM_CLIENTS; c++)
      for (int r = 0; r < NUM_CLIENTS; r++)
        if (r != c && req[r] && m[r][c]) g[c] = 1'b0;
    return g;
  endfunction

  function automatic prio_matrix_t from_upper(prio_matrix_t src);
    prio_matrix_t m;
    for (int r = 0; r < NUM_CLIENTS; r++)
      for (int c = 0; c < NUM_CLIENTS; c++)
        m[r][c] = (c > r) ? src[r][c] : (c < r) ? !src[c][r] : 1'b0;
    return m;
  endfunction

  // Move one client to the top or the bottom of the order
  function automatic prio_matrix_t ref_matrix(prio_matrix_t m, arb_policy_e p,
                                              logic [NUM_CLIENTS-1:0] grant);
    int  k;
    int  beaten_by;
    bit  to_top;
    k = -1;
    to_top = (p == ARB_DEC_ROUND_ROBIN || p == ARB_MRU);
    for (int r = 0; r < NUM_CLIENTS; r++) begin
      beaten_by = 0;
      for (int x = 0; x < NUM_CLIENTS; x++) beaten_by += m[x][r];
      if (p == ARB_ROUND_ROBIN && $countones(m[r]) == NUM_CLIENTS - 1) k = r;
      if (p == ARB_DEC_ROUND_ROBIN && beaten_by == NUM_CLIENTS - 1) k = r;
      if ((p == ARB_LRU || p == ARB_MRU) && grant[r]) k = r;
    end
    if (k >= 0) begin
      for (int x = 0; x < NUM_CLIENTS; x++) begin
        if (x != k) begin
          m[k][x] = to_top;
          m[x][k] = !to_top;
        end
      end
    end
    return m;
  endfunction

  // ****************************************
  // Compare, then step the model past the next edge
  // ****************************************
  always @(negedge i_clk) begin : p_compare
    logic [NUM_CLIENTS-1:0] grant;
    if (!i_rst_n) begin
      model_pending = '0;
      exp_valid     = 1'b0;
      model_matrix  = from_upper(RESET_MATRIX);
    end else begin
      check_value("rsp_valid", exp_valid ? (32'd1 << exp_client) : 32'd0, i_rsp_valid);
      if (exp_valid) check_value("rsp_rdata", exp_data, i_rsp_rdata[exp_client]);
      check_value("busy", model_pending, i_busy);

      grant     = ref_grant(model_matrix, model_pending);
      exp_valid = |grant;
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (grant[c]) begin
          exp_client = c;
          exp_data   = model_access[c].write ? '0 : model_mem[model_access[c].addr];
          if (model_access[c].write) model_mem[model_access[c].addr] = model_access[c].wdata;
        end
      end

      if (i_cfg.load) model_matrix = from_upper(i_cfg.matrix);
      else if (|model_pending) model_matrix = ref_matrix(model_matrix, i_cfg.policy, grant);

      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (i_acc_valid[c] && !model_pending[c]) begin
          model_pending[c] = 1'b1;
          model_access[c]  = i_access[c];
        end else if (grant[c]) begin
          model_pending[c] = 1'b0;
        end
      end
    end
  end

endmodule

// ==== verification/tb_mem_share_top.sv ====
/* Shared memory testbench
   Clock, reset, client stimulus per test, watchdog and final summary */
module tb_mem_share_top;
  import mem_arb_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_TESTS       = 6;
  localparam int MAX_TEST_CYCLES = 400;  // Single-client test runs 80 accesses
  localparam int TIMEOUT         = (16 + NUM_TESTS * MAX_TEST_CYCLES) * CLK_PERIOD;

  logic                                 clk;
  logic                                 rst_n;
  arb_config_t                          cfg;
  logic [NUM_CLIENTS-1:0]               acc_valid;
  mem_access_t [NUM_CLIENTS-1:0]        access;
  logic [NUM_CLIENTS-1:0]               busy;
  logic [NUM_CLIENTS-1:0]               rsp_valid;
  logic [NUM_CLIENTS-1:0][DATA_W-1:0]   rsp_rdata;
  logic [31:0]                          rng_state;
  int                                   pass_count;
  int                                   fail_count;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mem_share_top UUT (
    .i_clk (clk), .i_rst_n (rst_n), .i_cfg (cfg), .i_acc_valid (acc_valid),
    .i_access (access), .o_busy (busy), .o_rsp_valid (rsp_valid), .o_rsp_rdata (rsp_rdata)
  );

  mem_share_monitor u_monitor (
    .i_clk (clk), .i_rst_n (rst_n), .i_cfg (cfg), .i_acc_valid (acc_valid),
    .i_access (access), .i_busy (busy), .i_rsp_valid (rsp_valid), .i_rsp_rdata (rsp_rdata)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // ****************************************
  // Stimulus helpers
  // ****************************************
  task automatic step();
    @(posedge clk);
    #1;
    acc_valid = '0;  // Strobes and loads last one cycle
    cfg.load  = 1'b0;
  endtask

  task automatic set_access(input int c, input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
    acc_valid[c] = 1'b1;
    access[c]    = '{write: wr, addr: addr, wdata: data};
  endtask

  task automatic set_random(input int c);
    rng_state = xorshift32(rng_state);
    set_access(c, rng_state[0], rng_state[6:1], rng_state[31:16]);
  endtask

  task automatic load_matrix(input prio_matrix_t m);
    cfg.load   = 1'b1;
    cfg.matrix = m;
    step();
  endtask

  task automatic wait_idle();
    while (busy != '0) step();
    step();  // Last response pulse
    step();
  endtask

  // Client 0 alone, strobe to response measured in cycles
  task automatic single_access(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
    int n;
    set_access(0, wr, addr, data);
    step();
    n = 1;
    while (!rsp_valid[0] && n < 10) begin
      step();
      n++;
    end
    u_monitor.check_value("latency", 2, n);
  endtask

  // Each idle client strobes with probability one half
  task automatic contend(input int cycles);
    repeat (cycles) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        rng_state = xorshift32(rng_state);
        if (!busy[c] && rng_state[3]) set_random(c);
      end
      step();
    end
    wait_idle();
  endtask

  task automatic finish_test(input string name);
    if (u_monitor.test_errors == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, u_monitor.test_errors);
    end
  endtask

  // ****************************************
  // Test sequence
  // ****************************************
  initial begin : p_main
    int n;
    clk = 1'b0;
    rst_n = 1'b0;
    cfg = '{policy: ARB_ROUND_ROBIN, load: 1'b0, matrix: RESET_MATRIX};
    acc_valid = '0;
    access = '0;
    rng_state = 32'd41;
    pass_count = 0;
    fail_count = 0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    u_monitor.start_test("single_client");
    for (int a = 0; a < MEM_DEPTH; a++) begin
      rng_state = xorshift32(rng_state);
      single_access(1'b1, ADDR_W'(a), rng_state[31:16]);
    end
    repeat (16) begin
      rng_state = xorshift32(rng_state);
      single_access(1'b0, rng_state[ADDR_W-1:0], '0);
    end
    wait_idle();
    finish_test("single_client");

    u_monitor.start_test("all_round_robin");
    load_matrix(RESET_MATRIX);
    repeat (3) begin
      for (int c = 0; c < NUM_CLIENTS; c++) set_random(c);
      step();
      wait_idle();
    end
    finish_test("all_round_robin");

    u_monitor.start_test("lru_contention");
    cfg.policy = ARB_LRU;
    contend(40);
    finish_test("lru_contention");

    u_monitor.start_test("mru_contention");
    cfg.policy = ARB_MRU;
    contend(40);
    finish_test("mru_contention");

    u_monitor.start_test("dec_round_robin");
    cfg.policy = ARB_DEC_ROUND_ROBIN;
    // Clients join one per cycle, then every idle one strobes again
    repeat (4) begin
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        for (int k = 0; k <= c; k++) begin
          if (!busy[k]) set_random(k);
        end
        step();
      end
    end
    wait_idle();
    finish_test("dec_round_robin");

    u_monitor.start_test("matrix_load");
    cfg.policy = ARB_LRU;
    load_matrix('0);  // Upper triangle clear, higher index wins
    for (int c = 0; c < NUM_CLIENTS; c++) set_random(c);
    step();
    n = 0;
    while (rsp_valid == '0 && n < 20) begin
      step();
      n++;
    end
    u_monitor.check_value("first responder", 4'b1000, rsp_valid);
    load_matrix(RESET_MATRIX);  // Reload while three accesses still wait
    wait_idle();
    finish_test("matrix_load");

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors, %0d assertion failures",
             pass_count, fail_count, u_monitor.error_count,
             UUT.u_arbiter.u_arbiter_checker.fail_count);
    if (fail_count == 0 && u_monitor.error_count == 0 &&
        UUT.u_arbiter.u_arbiter_checker.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(TIMEOUT);
    $display("Timeout: run exceeded %0d time units before all tests finished", TIMEOUT);
    $display("test failed");
    $finish;
  end

endmodule

// ==== mem_share_top.f ====
hdl/mem_arb_pkg.sv
hdl/matrix_arbiter.sv
hdl/client_port.sv
hdl/shared_ram.sv
hdl/mem_share_top.sv
verification/arbiter_checker.sv
verification/mem_share_monitor.sv
verification/tb_mem_share_top.sv
